//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal -f sim.f --top-module tb_sb_node -o tb_sb_node
obj_dir/tb_sb_node > sim.log 2>&1 || true
cat sim.log
if grep -q "Simulation failed" sim.log; then
    exit 1
fi
grep -q "Simulation passed" sim.log

//--- sim.f
verilog/sb_pkg.sv
verilog/sb_if.sv
verilog/sb_ism.sv
verilog/sb_tx_port.sv
verilog/sb_rx_port.sv
verilog/sb_mux.sv
verilog/sb_node.sv
tb/tb_sb_node.sv

//--- tb/tb_sb_node.sv
`timescale 1ns/10ps

module tb_sb_node;

    localparam int CREDIT_MAX = 3;
    localparam int RX_CREDITS = 2;
    localparam int TIMEOUT    = 2000;

    logic        side_clk;
    logic        reset;
    logic        tx_valid, tx_ready, tx_eom, tx_np;
    logic [31:0] tx_payload;
    logic        rx_valid, rx_ready, rx_eom, rx_np, rx_err;
    logic [31:0] rx_payload;
    logic [2:0]  agt_ism_agt, agt_ism_fab, fab_ism_agt, fab_ism_fab;
    logic        agt_mpccup, agt_mnpcup, agt_mpcput, agt_mnpput, agt_meom, agt_mparity;
    logic        agt_tpccup, agt_tnpcup, agt_tpcput, agt_tnpput, agt_teom, agt_tparity;
    logic        fab_mpccup, fab_mnpcup, fab_mpcput, fab_mnpput, fab_meom, fab_mparity;
    logic        fab_tpccup, fab_tnpcup, fab_tpcput, fab_tnpput, fab_teom, fab_tparity;
    logic [31:0] agt_mpayload, agt_tpayload, fab_mpayload, fab_tpayload;

    // far-end model state.
    logic [31:0]  seed = 32'd56;
    sb_pkg::ism_e ism_req;
    bit           link_up;
    bit           traffic_on;
    bit           rx_stall;
    int           tx_cred [2];
    int           rx_cred [2];
    int           rx_owed [2];
    logic [33:0]  tx_exp [$];
    logic [34:0]  rx_exp [$];
    int           tx_left;
    logic         tx_cur_np;
    logic         tx_fired;
    logic         m_in_msg;
    int           t_left;
    logic         t_np;
    int           tx_msgs;
    int           rx_msgs;

    sb_node #(
        .CREDIT_MAX (CREDIT_MAX),
        .RX_CREDITS (RX_CREDITS),
        .MAX_FLITS  (4),
        .ENDPOINT   (0),
        .AGT        (1)
    ) i_sb_node (.*);

    always #50 side_clk = ~side_clk;

    function automatic logic [31:0] next_rand();
        seed = seed ^ (seed << 13);
        seed = seed ^ (seed >> 17);
        seed = seed ^ (seed << 5);
        return seed;
    endfunction

    task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("ERR at %0t: %s is 'h%0h, expected 'h%0h", $time, name, got, exp);
            $display("Simulation failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic fail_with(input string why);
        $display("at %0t: %s", $time, why);
        $display("Simulation failed");
        $fatal(1, "run stopped");
    endtask

    // one clock that samples at the falling edge, drives, then records handshakes.
    task automatic step();
        logic [33:0] tf;
        logic [34:0] rf;
        logic [31:0] r;
        logic        err;
        @(negedge side_clk);
        check_val("fab_outputs", {fab_ism_agt, fab_mpcput, fab_mnpput, fab_mpayload, fab_meom,
                  fab_mparity, fab_tpccup, fab_tnpcup}, '0);
        // every target flit sent before this edge sits in the buffer until taken.
        check_val("rx_valid", rx_valid, rx_exp.size() != 0);
        check_val("agt_tpcput|agt_tnpput", agt_tpcput | agt_tnpput, tx_fired);
        if (agt_tpcput || agt_tnpput) begin
            tf = tx_exp.pop_front();
            check_val("agt_tnpput", agt_tnpput, tf[33]);
            check_val("agt_tpcput", agt_tpcput, !tf[33]);
            check_val("agt_teom", agt_teom, tf[32]);
            check_val("agt_tpayload", agt_tpayload, tf[31:0]);
            check_val("agt_tparity", agt_tparity, ^tf[32:0]);
            if (!m_in_msg) begin
                if (tx_cred[agt_tnpput] == 0) begin
                    fail_with("node started a message without a credit of its class");
                end
                tx_cred[agt_tnpput]--;
            end
            m_in_msg = !agt_teom;
        end
        if (agt_mpccup) begin
            if (rx_owed[0] == 0) fail_with("node returned a posted credit it did not owe");
            rx_owed[0]--;
            rx_cred[0]++;
        end
        if (agt_mnpcup) begin
            if (rx_owed[1] == 0) fail_with("node returned a non-posted credit it did not owe");
            rx_owed[1]--;
            rx_cred[1]++;
        end

        agt_ism_agt = ism_req;
        // local sender.
        if (tx_fired) begin
            tx_valid = 1'b0;
            tx_left--;
        end
        r = next_rand();
        if (!tx_valid && tx_left == 0 && traffic_on && r[1:0] == 2'd0) begin
            tx_left   = 1 + int'(r[3:2]);
            tx_cur_np = r[4];
        end
        if (!tx_valid && tx_left > 0 && r[6:5] != 2'd0) begin
            tx_valid   = 1'b1;
            tx_payload = next_rand();
            tx_eom     = (tx_left == 1);
            tx_np      = tx_cur_np;
        end
        // credit grants stop at the counter limit.
        agt_tpccup = 1'b0;
        agt_tnpcup = 1'b0;
        r = next_rand();
        if (link_up && tx_cred[0] < CREDIT_MAX && r[1:0] == 2'd0) begin
            agt_tpccup = 1'b1;
            tx_cred[0]++;
        end
        if (link_up && tx_cred[1] < CREDIT_MAX && r[3:2] == 2'd0) begin
            agt_tnpcup = 1'b1;
            tx_cred[1]++;
        end
        // target messages go out only with a credit in hand.
        agt_mpcput = 1'b0;
        agt_mnpput = 1'b0;
        r = next_rand();
        if (t_left == 0 && traffic_on && link_up && r[1:0] == 2'd0 && rx_cred[r[2]] > 0) begin
            t_np = r[2];
            rx_cred[t_np]--;
            t_left = 1 + int'(r[4:3]);
        end
        if (t_left > 0) begin
            err          = (r[7:5] == 3'd0);
            agt_mpcput   = !t_np;
            agt_mnpput   = t_np;
            agt_mpayload = next_rand();
            agt_meom     = (t_left == 1);
            agt_mparity  = ^{agt_mpayload, agt_meom} ^ err;
            rx_exp.push_back({t_np, err, agt_meom, agt_mpayload});
            t_left--;
        end
        r = next_rand();
        rx_ready = rx_stall ? (r[1:0] == 2'd0) : (r[1:0] != 2'd0);

        #10;
        tx_fired = tx_valid && tx_ready;
        if (tx_fired) begin
            tx_exp.push_back({tx_np, tx_eom, tx_payload});
            if (tx_eom) tx_msgs++;
        end
        if (rx_valid && rx_ready) begin
            if (rx_exp.size() == 0) fail_with("rx_valid with no target flit outstanding");
            rf = rx_exp.pop_front();
            check_val("rx_payload", rx_payload, rf[31:0]);
            check_val("rx_eom", rx_eom, rf[32]);
            check_val("rx_err", rx_err, rf[33]);
            check_val("rx_np", rx_np, rf[34]);
            if (rf[32]) begin
                rx_owed[rf[34]]++;
                rx_msgs++;
            end
        end
    endtask

    task automatic bring_up();
        int n;
        check_val("agt_ism_fab", agt_ism_fab, sb_pkg::ism_idle);
        tx_cred = '{0, 0};
        rx_cred = '{0, 0};
        rx_owed = '{RX_CREDITS, RX_CREDITS};
        m_in_msg = 1'b0;
        n = 0;
        while (agt_ism_fab != sb_pkg::ism_active_req) begin
            check_val("tx_ready", tx_ready, 1'b0);
            step();
            n++;
            if (n > TIMEOUT) fail_with("agent never requested the active state");
        end
        ism_req = sb_pkg::ism_active;
        step();
        check_val("tx_ready", tx_ready, 1'b0);
        step();
        check_val("agt_ism_fab", agt_ism_fab, sb_pkg::ism_active);
        link_up = 1'b1;
    endtask

    // let every message and credit settle before the link drop.
    task automatic quiesce();
        int n;
        traffic_on = 1'b0;
        rx_stall   = 1'b0;
        n = 0;
        while (tx_valid || tx_left != 0 || t_left != 0 || tx_exp.size() != 0 ||
               rx_exp.size() != 0 || rx_owed[0] != 0 || rx_owed[1] != 0) begin
            step();
            n++;
            if (n > TIMEOUT) fail_with("traffic did not drain");
        end
    endtask

    task automatic drop_link();
        ism_req = sb_pkg::ism_idle;
        link_up = 1'b0;
        step();
        step();
        check_val("agt_ism_fab", agt_ism_fab, sb_pkg::ism_idle);
        check_val("tx_ready", tx_ready, 1'b0);
    endtask

    initial begin
        side_clk = 1'b0;
        reset = 1'b1;
        {tx_valid, tx_eom, tx_np, tx_payload, rx_ready} = '0;
        {agt_ism_agt, agt_mpcput, agt_mnpput, agt_mpayload, agt_meom, agt_mparity} = '0;
        {agt_tpccup, agt_tnpcup, fab_ism_fab, fab_mpccup, fab_mnpcup} = '0;
        {fab_tpcput, fab_tnpput, fab_tpayload, fab_teom, fab_tparity} = '0;
        ism_req = sb_pkg::ism_idle;
        {link_up, traffic_on, rx_stall, tx_fired, m_in_msg, t_np, tx_cur_np} = '0;
        tx_left = 0;
        t_left = 0;
        tx_msgs = 0;
        rx_msgs = 0;
        repeat (3) @(negedge side_clk);
        reset = 1'b0;
        bring_up();
        traffic_on = 1'b1;
        repeat (400) step();
        rx_stall = 1'b1;
        repeat (200) step();
        quiesce();
        drop_link();
        bring_up();
        traffic_on = 1'b1;
        repeat (300) step();
        quiesce();
        if (tx_msgs == 0 || rx_msgs == 0) begin
            $display("no messages passed through one of the ports");
            $display("Simulation failed");
            $fatal(1, "no traffic");
        end else begin
            $display("Simulation passed");
            $finish;
        end
    end

endmodule

//--- verilog/sb_if.sv
`timescale 1ns/10ps

interface sb_if;

    sb_pkg::ism_e side_ism_agent;
    sb_pkg::ism_e side_ism_fabric;

    // master channel, issued by the node.
    logic                         mpcput;
    logic                         mnpput;
    logic [sb_pkg::PAYLOAD_W-1:0] mpayload;
    logic                         meom;
    logic                         mparity;
    logic                         mpccup;
    logic                         mnpcup;

    // target channel, received by the node.
    logic                         tpcput;
    logic                         tnpput;
    logic [sb_pkg::PAYLOAD_W-1:0] tpayload;
    logic                         teom;
    logic                         tparity;
    logic                         tpccup;
    logic                         tnpcup;

    modport ism (
        output side_ism_agent,
        input  side_ism_fabric
    );

    modport tx (
        output mpcput, mnpput, mpayload, meom, mparity,
        input  mpccup, mnpcup
    );

    modport rx (
        output tpccup, tnpcup,
        input  tpcput, tnpput, tpayload, teom, tparity
    );

    modport link (
        input  side_ism_agent, mpcput, mnpput, mpayload, meom, mparity, tpccup, tnpcup,
        output side_ism_fabric, mpccup, mnpcup, tpcput, tnpput, tpayload, teom, tparity
    );

endinterface

//--- verilog/sb_ism.sv
`timescale 1ns/10ps

module sb_ism (
    input  logic side_clk,
    input  logic reset,
    sb_if.ism    link,
    output logic active
);

    sb_pkg::ism_e state;

    always_ff @(posedge side_clk) begin
        if (reset) begin
            state <= sb_pkg::ism_idle;
        end else begin
            case (state)
                sb_pkg::ism_idle: begin
                    state <= sb_pkg::ism_active_req;
                end
                sb_pkg::ism_active_req: begin
                    if (link.side_ism_fabric == sb_pkg::ism_active) begin
                        state <= sb_pkg::ism_active;
                    end
                end
                sb_pkg::ism_active: begin
                    // fabric dropped the link.
                    if (link.side_ism_fabric != sb_pkg::ism_active) begin
                        state <= sb_pkg::ism_idle;
                    end
                end
                default: begin
                    state <= sb_pkg::ism_idle;
                end
            endcase
        end
    end

    assign link.side_ism_agent = state;
    assign active = (state == sb_pkg::ism_active);

endmodule

//--- verilog/sb_mux.sv
`timescale 1ns/10ps

module sb_mux #(
    parameter int ENDPOINT = 0,
    parameter int AGT      = 1
) (
    input  logic [sb_pkg::ISM_W-1:0]     agt_ism_agt,
    output logic                         agt_mpccup,
    output logic                         agt_mnpcup,
    input  logic                         agt_mpcput,
    input  logic                         agt_mnpput,
    input  logic [sb_pkg::PAYLOAD_W-1:0] agt_mpayload,
    input  logic                         agt_meom,
    input  logic                         agt_mparity,
    output logic [sb_pkg::ISM_W-1:0]     agt_ism_fab,
    input  logic                         agt_tpccup,
    input  logic                         agt_tnpcup,
    output logic                         agt_tpcput,
    output logic                         agt_tnpput,
    output logic [sb_pkg::PAYLOAD_W-1:0] agt_tpayload,
    output logic                         agt_teom,
    output logic                         agt_tparity,
    output logic [sb_pkg::ISM_W-1:0]     fab_ism_agt,
    input  logic                         fab_mpccup,
    input  logic                         fab_mnpcup,
    output logic                         fab_mpcput,
    output logic                         fab_mnpput,
    output logic [sb_pkg::PAYLOAD_W-1:0] fab_mpayload,
    output logic                         fab_meom,
    output logic                         fab_mparity,
    input  logic [sb_pkg::ISM_W-1:0]     fab_ism_fab,
    output logic                         fab_tpccup,
    output logic                         fab_tnpcup,
    input  logic                         fab_tpcput,
    input  logic                         fab_tnpput,
    input  logic [sb_pkg::PAYLOAD_W-1:0] fab_tpayload,
    input  logic                         fab_teom,
    input  logic                         fab_tparity,
    sb_if.link                           node
);

    // agt pins are named from the far end, so master and target cross there.
    // fab pins face the node straight. a fabric-end node takes the other group.
    if ((AGT != 0) != (ENDPOINT != 0)) begin : g_agt
        assign agt_ism_fab          = node.side_ism_agent;
        assign node.side_ism_fabric = sb_pkg::ism_e'(agt_ism_agt);
        assign agt_tpcput           = node.mpcput;
        assign agt_tnpput           = node.mnpput;
        assign agt_tpayload         = node.mpayload;
        assign agt_teom             = node.meom;
        assign agt_tparity          = node.mparity;
        assign node.mpccup          = agt_tpccup;
        assign node.mnpcup          = agt_tnpcup;
        assign node.tpcput          = agt_mpcput;
        assign node.tnpput          = agt_mnpput;
        assign node.tpayload        = agt_mpayload;
        assign node.teom            = agt_meom;
        assign node.tparity         = agt_mparity;
        assign agt_mpccup           = node.tpccup;
        assign agt_mnpcup           = node.tnpcup;
        assign {fab_ism_agt, fab_mpcput, fab_mnpput, fab_mpayload, fab_meom, fab_mparity,
                fab_tpccup, fab_tnpcup} = '0;
    end else begin : g_fab
        assign fab_ism_agt          = node.side_ism_agent;
        assign node.side_ism_fabric = sb_pkg::ism_e'(fab_ism_fab);
        assign fab_mpcput           = node.mpcput;
        assign fab_mnpput           = node.mnpput;
        assign fab_mpayload         = node.mpayload;
        assign fab_meom             = node.meom;
        assign fab_mparity          = node.mparity;
        assign node.mpccup          = fab_mpccup;
        assign node.mnpcup          = fab_mnpcup;
        assign node.tpcput          = fab_tpcput;
        assign node.tnpput          = fab_tnpput;
        assign node.tpayload        = fab_tpayload;
        assign node.teom            = fab_teom;
        assign node.tparity         = fab_tparity;
        assign fab_tpccup           = node.tpccup;
        assign fab_tnpcup           = node.tnpcup;
        assign {agt_ism_fab, agt_tpcput, agt_tnpput, agt_tpayload, agt_teom, agt_tparity,
                agt_mpccup, agt_mnpcup} = '0;
    end

endmodule

//--- verilog/sb_node.sv
`timescale 1ns/10ps

module sb_node #(
    parameter int CREDIT_MAX = 3,
    parameter int RX_CREDITS = 2,
    parameter int MAX_FLITS  = 4,
    parameter int ENDPOINT   = 0,
    parameter int AGT        = 1
) (
    input  logic                         side_clk,
    input  logic                         reset,
    input  logic                         tx_valid,
    output logic                         tx_ready,
    input  logic [sb_pkg::PAYLOAD_W-1:0] tx_payload,
    input  logic                         tx_eom,
    input  logic                         tx_np,
    output logic                         rx_valid,
    input  logic                         rx_ready,
    output logic [sb_pkg::PAYLOAD_W-1:0] rx_payload,
    output logic                         rx_eom,
    output logic                         rx_np,
    output logic                         rx_err,
    input  logic [sb_pkg::ISM_W-1:0]     agt_ism_agt,
    output logic                         agt_mpccup,
    output logic                         agt_mnpcup,
    input  logic                         agt_mpcput,
    input  logic                         agt_mnpput,
    input  logic [sb_pkg::PAYLOAD_W-1:0] agt_mpayload,
    input  logic                         agt_meom,
    input  logic                         agt_mparity,
    output logic [sb_pkg::ISM_W-1:0]     agt_ism_fab,
    input  logic                         agt_tpccup,
    input  logic                         agt_tnpcup,
    output logic                         agt_tpcput,
    output logic                         agt_tnpput,
    output logic [sb_pkg::PAYLOAD_W-1:0] agt_tpayload,
    output logic                         agt_teom,
    output logic                         agt_tparity,
    output logic [sb_pkg::ISM_W-1:0]     fab_ism_agt,
    input  logic                         fab_mpccup,
    input  logic                         fab_mnpcup,
    output logic                         fab_mpcput,
    output logic                         fab_mnpput,
    output logic [sb_pkg::PAYLOAD_W-1:0] fab_mpayload,
    output logic                         fab_meom,
    output logic                         fab_mparity,
    input  logic [sb_pkg::ISM_W-1:0]     fab_ism_fab,
    output logic                         fab_tpccup,
    output logic                         fab_tnpcup,
    input  logic                         fab_tpcput,
    input  logic                         fab_tnpput,
    input  logic [sb_pkg::PAYLOAD_W-1:0] fab_tpayload,
    input  logic                         fab_teom,
    input  logic                         fab_tparity
);

    logic active;

    sb_if sb_link ();

    sb_ism i_sb_ism (
        .side_clk (side_clk),
        .reset    (reset),
        .link     (sb_link.ism),
        .active   (active)
    );

    sb_tx_port #(
        .CREDIT_MAX (CREDIT_MAX)
    ) i_sb_tx_port (
        .*,
        .link (sb_link.tx)
    );

    sb_rx_port #(
        .RX_CREDITS (RX_CREDITS),
        .MAX_FLITS  (MAX_FLITS)
    ) i_sb_rx_port (
        .*,
        .link (sb_link.rx)
    );

    sb_mux #(
        .ENDPOINT (ENDPOINT),
        .AGT      (AGT)
    ) i_sb_mux (
        .*,
        .node (sb_link.link)
    );

endmodule

//--- verilog/sb_pkg.sv
package sb_pkg;

    // flit payload and link state widths.
    localparam int PAYLOAD_W = 32;
    localparam int ISM_W = 3;

    typedef enum logic [ISM_W-1:0] {
        ism_idle       = 3'd0,
        ism_active_req = 3'd1,
        ism_active     = 3'd3
    } ism_e;

    typedef enum logic {
        cls_posted    = 1'b0,
        cls_nonposted = 1'b1
    } msg_class_e;

endpackage

//--- verilog/sb_rx_port.sv
`timescale 1ns/10ps

module sb_rx_port #(
    parameter int RX_CREDITS = 2,
    parameter int MAX_FLITS  = 4
) (
    input  logic                         side_clk,
    input  logic                         reset,
    input  logic                         active,
    output logic                         rx_valid,
    input  logic                         rx_ready,
    output logic [sb_pkg::PAYLOAD_W-1:0] rx_payload,
    output logic                         rx_eom,
    output logic                         rx_np,
    output logic                         rx_err,
    sb_if.rx                             link
);

    localparam int DEPTH   = 2 * RX_CREDITS * MAX_FLITS;
    localparam int AW      = $clog2(DEPTH);
    localparam int CNTW    = AW + 1;
    localparam int OW      = $clog2(RX_CREDITS + 1);
    localparam int ENTRY_W = sb_pkg::PAYLOAD_W + 3;

    logic [ENTRY_W-1:0] mem [DEPTH];
    logic [AW-1:0]      wr_ptr;
    logic [AW-1:0]      rd_ptr;
    logic [CNTW-1:0]    count;
    logic [ENTRY_W-1:0] head;
    logic               wr;
    logic               rd;
    logic               flit_err;
    sb_pkg::msg_class_e in_cls;
    sb_pkg::msg_class_e head_cls;
    logic [OW-1:0]      owed_pc;
    logic [OW-1:0]      owed_np;
    logic               give_pc;
    logic               give_np;
    logic               ret_pc;
    logic               ret_np;

    function automatic logic [AW-1:0] next_ptr(logic [AW-1:0] ptr);
        return (ptr == AW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign in_cls   = link.tnpput ? sb_pkg::cls_nonposted : sb_pkg::cls_posted;
    assign flit_err = ^{link.tpayload, link.teom, link.tparity};
    assign wr       = active && (link.tpcput || link.tnpput);
    assign rd       = rx_valid && rx_ready;

    // entry layout is class, parity error, eom, payload.
    assign head       = mem[rd_ptr];
    assign head_cls   = sb_pkg::msg_class_e'(head[ENTRY_W-1]);
    assign rx_valid   = (count != '0);
    assign rx_err     = head[ENTRY_W-2];
    assign rx_eom     = head[sb_pkg::PAYLOAD_W];
    assign rx_payload = head[sb_pkg::PAYLOAD_W-1:0];
    assign rx_np      = (head_cls == sb_pkg::cls_nonposted);

    // a finished message frees one credit of its class.
    assign ret_pc  = rd && rx_eom && (head_cls == sb_pkg::cls_posted);
    assign ret_np  = rd && rx_eom && (head_cls == sb_pkg::cls_nonposted);
    // one cup per cycle, posted first.
    assign give_pc = (owed_pc != '0);
    assign give_np = (owed_pc == '0) && (owed_np != '0);

    always_ff @(posedge side_clk) begin
        if (wr) begin
            mem[wr_ptr] <= {in_cls, flit_err, link.teom, link.tpayload};
        end
    end

    // a link drop discards what is still buffered and re-arms the advertisement.
    always_ff @(posedge side_clk) begin
        if (reset || !active) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            owed_pc     <= OW'(RX_CREDITS);
            owed_np     <= OW'(RX_CREDITS);
            link.tpccup <= 1'b0;
            link.tnpcup <= 1'b0;
        end else begin
            if (wr) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (rd) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            count       <= count + CNTW'(wr) - CNTW'(rd);
            owed_pc     <= owed_pc + OW'(ret_pc) - OW'(give_pc);
            owed_np     <= owed_np + OW'(ret_np) - OW'(give_np);
            link.tpccup <= give_pc;
            link.tnpcup <= give_np;
        end
    end

endmodule

//--- verilog/sb_tx_port.sv
`timescale 1ns/10ps

module sb_tx_port #(
    parameter int CREDIT_MAX = 3
) (
    input  logic                         side_clk,
    input  logic                         reset,
    input  logic                         active,
    input  logic                         tx_valid,
    output logic                         tx_ready,
    input  logic [sb_pkg::PAYLOAD_W-1:0] tx_payload,
    input  logic                         tx_eom,
    input  logic                         tx_np,
    sb_if.tx                             link
);

    localparam int CW = $clog2(CREDIT_MAX + 1);

    logic [CW-1:0]      pc_cred;
    logic [CW-1:0]      np_cred;
    logic               in_msg;
    sb_pkg::msg_class_e msg_cls;
    sb_pkg::msg_class_e flit_cls;
    logic               have_cred;
    logic               accept;
    logic               take_pc;
    logic               take_np;

    // one step of a credit counter, saturating at CREDIT_MAX.
    function automatic logic [CW-1:0] step_cred(logic [CW-1:0] cnt, logic cup, logic take);
        logic [CW-1:0] res;
        res = cnt;
        if (cup && !take && cnt != CW'(CREDIT_MAX)) begin
            res = cnt + 1'b1;
        end else if (take && !cup) begin
            res = cnt - 1'b1;
        end
        return res;
    endfunction

    // class is held for the rest of a message once its first flit goes.
    assign flit_cls  = in_msg ? msg_cls : sb_pkg::msg_class_e'(tx_np);
    assign have_cred = (flit_cls == sb_pkg::cls_nonposted) ? (np_cred != '0) : (pc_cred != '0);
    assign tx_ready  = active && (in_msg || have_cred);
    assign accept    = tx_valid && tx_ready;
    assign take_pc   = accept && !in_msg && (flit_cls == sb_pkg::cls_posted);
    assign take_np   = accept && !in_msg && (flit_cls == sb_pkg::cls_nonposted);

    always_ff @(posedge side_clk) begin
        if (reset || !active) begin
            pc_cred     <= '0;
            np_cred     <= '0;
            in_msg      <= 1'b0;
            msg_cls     <= sb_pkg::cls_posted;
            link.mpcput <= 1'b0;
            link.mnpput <= 1'b0;
        end else begin
            pc_cred <= step_cred(pc_cred, link.mpccup, take_pc);
            np_cred <= step_cred(np_cred, link.mnpcup, take_np);
            if (accept) begin
                in_msg  <= !tx_eom;
                msg_cls <= flit_cls;
            end
            link.mpcput <= accept && (flit_cls == sb_pkg::cls_posted);
            link.mnpput <= accept && (flit_cls == sb_pkg::cls_nonposted);
        end
    end

    // even parity over payload and eom.
    always_ff @(posedge side_clk) begin
        if (accept) begin
            link.mpayload <= tx_payload;
            link.meom     <= tx_eom;
            link.mparity  <= ^{tx_payload, tx_eom};
        end
    end

endmodule
